/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_chip_board_top
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIM       = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
pad_pkg.sv
periph_pkg.sv
cfg_if.sv
rst_ctrl.sv
padring.sv
pinmux.sv
uart_tx.sv
cfg_regs.sv
chip_core.sv
chip_board_top.sv
tb_chip_board_top.sv

/* cfg_if.sv */
// Four-phase req/ack configuration bus
// The host holds req until ack, the device holds ack until req drops
`timescale 1ns/1ps
`default_nettype none

interface cfg_if;

  logic                         req;
  logic                         ack;
  logic                         we;
  logic [periph_pkg::CfgAw-1:0] addr;
  logic [periph_pkg::CfgDw-1:0] wdata;
  // Valid while ack is high
  logic [periph_pkg::CfgDw-1:0] rdata;

  modport host (output req, we, addr, wdata, input ack, rdata);
  modport dev  (input req, we, addr, wdata, output ack, rdata);

endinterface : cfg_if

`default_nettype wire

/* cfg_regs.sv */
// Control register block behind the four-phase configuration bus
// Holds GPIO, mux, attribute and UART registers and decodes reads
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
  input  wire logic                                              clk_i,
  input  wire logic                                              rst_i,
  cfg_if.dev                                                     cfg,
  input  wire logic [pad_pkg::NMioPads-1:0]                      gpio_in_i,
  input  wire logic                                              sense_i,
  input  wire logic                                              uart_busy_i,
  output logic      [pad_pkg::NMioPads-1:0]                      gpio_out_o,
  output logic      [pad_pkg::NMioPads-1:0]                      gpio_oe_o,
  output logic      [pad_pkg::NMioPads-1:0]                      mux_sel_o,
  output logic      [pad_pkg::NMioPads-1:0][pad_pkg::AttrDw-1:0] mio_attr_o,
  output logic      [pad_pkg::NDioPads-1:0][pad_pkg::AttrDw-1:0] dio_attr_o,
  output logic                                                   uart_start_o,
  output logic      [7:0]                                        uart_data_o
);

  localparam int MioAttrW = pad_pkg::NMioPads * pad_pkg::AttrDw;
  localparam int DioAttrW = pad_pkg::NDioPads * pad_pkg::AttrDw;

  logic                         ack_q;
  logic                         accept;
  logic [periph_pkg::CfgDw-1:0] rdata_d, rdata_q;

  logic [pad_pkg::NMioPads-1:0] gpio_out_q, gpio_oe_q, mux_sel_q;
  logic [MioAttrW-1:0]          mio_attr_q;
  logic [DioAttrW-1:0]          dio_attr_q;
  logic [7:0]                   uart_data_q;

  // New request while ack is low
  assign accept = cfg.req & ~ack_q;

  //////////////////////////////////////////////////////////////////////
  // Handshake and register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q       <= 1'b0;
      gpio_out_q  <= '0;
      gpio_oe_q   <= '0;
      mux_sel_q   <= {pad_pkg::NMioPads{periph_pkg::MuxSrcGpio}};
      mio_attr_q  <= '0;
      dio_attr_q  <= '0;
      uart_data_q <= '0;
    end else if (accept) begin
      ack_q <= 1'b1;
      if (cfg.we) begin
        case (cfg.addr)
          periph_pkg::RegGpioOut: gpio_out_q <= cfg.wdata[pad_pkg::NMioPads-1:0];
          periph_pkg::RegGpioOe:  gpio_oe_q  <= cfg.wdata[pad_pkg::NMioPads-1:0];
          periph_pkg::RegMuxSel:  mux_sel_q  <= cfg.wdata[pad_pkg::NMioPads-1:0];
          periph_pkg::RegMioAttr: mio_attr_q <= cfg.wdata[MioAttrW-1:0];
          periph_pkg::RegDioAttr: dio_attr_q <= cfg.wdata[DioAttrW-1:0];
          periph_pkg::RegUartData: begin
            if (!uart_busy_i) begin
              uart_data_q <= cfg.wdata[7:0];
            end
          end
          default: ;
        endcase
      end
    end else if (!cfg.req) begin
      ack_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    case (cfg.addr)
      periph_pkg::RegGpioOut:  rdata_d[pad_pkg::NMioPads-1:0] = gpio_out_q;
      periph_pkg::RegGpioOe:   rdata_d[pad_pkg::NMioPads-1:0] = gpio_oe_q;
      periph_pkg::RegGpioIn:   rdata_d[pad_pkg::NMioPads-1:0] = gpio_in_i;
      periph_pkg::RegMuxSel:   rdata_d[pad_pkg::NMioPads-1:0] = mux_sel_q;
      periph_pkg::RegMioAttr:  rdata_d[MioAttrW-1:0]          = mio_attr_q;
      periph_pkg::RegDioAttr:  rdata_d[DioAttrW-1:0]          = dio_attr_q;
      periph_pkg::RegUartData: rdata_d[7:0]                   = uart_data_q;
      periph_pkg::RegStatus:   rdata_d[1:0]                   = {sense_i, uart_busy_i};
      default: ;
    endcase
  end

  // Read data captured with the access, held while ack is high
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg.ack   = ack_q;
  assign cfg.rdata = rdata_q;

  // Start pulse lines up with the edge that raises ack
  assign uart_start_o = accept & cfg.we & (cfg.addr == periph_pkg::RegUartData) &
                        ~uart_busy_i;
  assign uart_data_o  = cfg.wdata[7:0];

  assign gpio_out_o = gpio_out_q;
  assign gpio_oe_o  = gpio_oe_q;
  assign mux_sel_o  = mux_sel_q;
  assign mio_attr_o = mio_attr_q;
  assign dio_attr_o = dio_attr_q;

endmodule : cfg_regs

`default_nettype wire

/* chip_board_top.sv */
// Board-level top for the I/O subsystem
// Pads appear as separate in, out and enable signals for the board flow
`timescale 1ns/1ps
`default_nettype none

module chip_board_top #(
  parameter int                           ClksPerBit    = 8,
  parameter int                           RstHoldCycles = 4,
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioIn  = 16'h0FFF,
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioOut = 16'h0FFF
) (
  input  wire logic                         io_clk_i,
  input  wire logic                         reset_i,
  // Configuration bus
  input  wire logic                         cfg_req_i,
  input  wire logic                         cfg_we_i,
  input  wire logic [periph_pkg::CfgAw-1:0] cfg_addr_i,
  input  wire logic [periph_pkg::CfgDw-1:0] cfg_wdata_i,
  output logic                              cfg_ack_o,
  output logic      [periph_pkg::CfgDw-1:0] cfg_rdata_o,
  // Pads
  input  wire logic [pad_pkg::NMioPads-1:0] mio_pad_i,
  output logic      [pad_pkg::NMioPads-1:0] mio_pad_o,
  output logic      [pad_pkg::NMioPads-1:0] mio_pad_oe_o,
  input  wire logic [pad_pkg::NDioPads-1:0] dio_pad_i,
  output logic      [pad_pkg::NDioPads-1:0] dio_pad_o,
  output logic      [pad_pkg::NDioPads-1:0] dio_pad_oe_o
);

  logic                                              core_rst;
  logic [pad_pkg::NMioPads-1:0]                      mio_out, mio_oe, mio_in;
  logic [pad_pkg::NDioPads-1:0]                      dio_out, dio_oe, dio_in;
  logic [pad_pkg::NMioPads-1:0][pad_pkg::AttrDw-1:0] mio_attr;
  logic [pad_pkg::NDioPads-1:0][pad_pkg::AttrDw-1:0] dio_attr;

  cfg_if cfg_bus ();

  // Board pins act as bus host
  assign cfg_bus.req   = cfg_req_i;
  assign cfg_bus.we    = cfg_we_i;
  assign cfg_bus.addr  = cfg_addr_i;
  assign cfg_bus.wdata = cfg_wdata_i;
  assign cfg_ack_o     = cfg_bus.ack;
  assign cfg_rdata_o   = cfg_bus.rdata;

  rst_ctrl #(
    .RstHoldCycles (RstHoldCycles)
  ) u_rst_ctrl (
    .clk_i   (io_clk_i),
    .reset_i (reset_i),
    .rst_o   (core_rst)
  );

  padring #(
    .ConnectMioIn  (ConnectMioIn),
    .ConnectMioOut (ConnectMioOut)
  ) u_padring (
    .mio_out_i    (mio_out),
    .mio_oe_i     (mio_oe),
    .mio_in_o     (mio_in),
    .dio_out_i    (dio_out),
    .dio_oe_i     (dio_oe),
    .dio_in_o     (dio_in),
    .mio_attr_i   (mio_attr),
    .dio_attr_i   (dio_attr),
    .mio_pad_i    (mio_pad_i),
    .mio_pad_o    (mio_pad_o),
    .mio_pad_oe_o (mio_pad_oe_o),
    .dio_pad_i    (dio_pad_i),
    .dio_pad_o    (dio_pad_o),
    .dio_pad_oe_o (dio_pad_oe_o)
  );

  chip_core #(
    .ClksPerBit (ClksPerBit)
  ) u_chip_core (
    .clk_i      (io_clk_i),
    .rst_i      (core_rst),
    .cfg        (cfg_bus),
    .mio_in_i   (mio_in),
    .dio_in_i   (dio_in),
    .mio_out_o  (mio_out),
    .mio_oe_o   (mio_oe),
    .dio_out_o  (dio_out),
    .dio_oe_o   (dio_oe),
    .mio_attr_o (mio_attr),
    .dio_attr_o (dio_attr)
  );

endmodule : chip_board_top

`default_nettype wire

/* chip_core.sv */
// Small I/O core with register block, UART transmitter and pin mux
// DIO 0 carries the UART line, DIO 1 is a sense input
`timescale 1ns/1ps
`default_nettype none

module chip_core #(
  parameter int ClksPerBit = 8
) (
  input  wire logic                                              clk_i,
  input  wire logic                                              rst_i,
  cfg_if.dev                                                     cfg,
  input  wire logic [pad_pkg::NMioPads-1:0]                      mio_in_i,
  input  wire logic [pad_pkg::NDioPads-1:0]                      dio_in_i,
  output logic      [pad_pkg::NMioPads-1:0]                      mio_out_o,
  output logic      [pad_pkg::NMioPads-1:0]                      mio_oe_o,
  output logic      [pad_pkg::NDioPads-1:0]                      dio_out_o,
  output logic      [pad_pkg::NDioPads-1:0]                      dio_oe_o,
  output logic      [pad_pkg::NMioPads-1:0][pad_pkg::AttrDw-1:0] mio_attr_o,
  output logic      [pad_pkg::NDioPads-1:0][pad_pkg::AttrDw-1:0] dio_attr_o
);

  logic [pad_pkg::NMioPads-1:0] gpio_out, gpio_oe, gpio_in, mux_sel;
  logic                         sense, uart_tx_line, uart_busy, uart_start;
  logic [7:0]                   uart_data;

  cfg_regs u_cfg_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg          (cfg),
    .gpio_in_i    (gpio_in),
    .sense_i      (sense),
    .uart_busy_i  (uart_busy),
    .gpio_out_o   (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .mux_sel_o    (mux_sel),
    .mio_attr_o   (mio_attr_o),
    .dio_attr_o   (dio_attr_o),
    .uart_start_o (uart_start),
    .uart_data_o  (uart_data)
  );

  uart_tx #(
    .ClksPerBit (ClksPerBit)
  ) u_uart_tx (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (uart_start),
    .data_i  (uart_data),
    .tx_o    (uart_tx_line),
    .busy_o  (uart_busy)
  );

  pinmux u_pinmux (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mux_sel_i   (mux_sel),
    .gpio_out_i  (gpio_out),
    .gpio_oe_i   (gpio_oe),
    .uart_tx_i   (uart_tx_line),
    .mio_in_i    (mio_in_i),
    .dio_sense_i (dio_in_i[pad_pkg::DioSense]),
    .mio_out_o   (mio_out_o),
    .mio_oe_o    (mio_oe_o),
    .gpio_in_o   (gpio_in),
    .sense_o     (sense)
  );

  // UART pad always driven, sense pad input only
  always_comb begin
    dio_out_o                     = '0;
    dio_oe_o                      = '0;
    dio_out_o[pad_pkg::DioUartTx] = uart_tx_line;
    dio_oe_o[pad_pkg::DioUartTx]  = 1'b1;
  end

endmodule : chip_core

`default_nettype wire

/* pad_pkg.sv */
// Pad ring dimensions and per-pad attribute encoding
// Shared by the pad ring, the register block and the board top
`default_nettype none

package pad_pkg;

  // Pad counts
  parameter int NMioPads = 16;
  parameter int NDioPads = 2;

  // Attribute word per pad
  parameter int AttrDw        = 2;
  parameter int AttrInvert    = 0;
  parameter int AttrOpenDrain = 1;

  // Dedicated pad assignment
  parameter int DioUartTx = 0;
  parameter int DioSense  = 1;

endpackage : pad_pkg

`default_nettype wire

/* padring.sv */
// Pad ring between the core and the board pins
// Applies invert, open-drain and connect masks, purely combinational
`timescale 1ns/1ps
`default_nettype none

module padring #(
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioIn  = '1,
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioOut = '1
) (
  // Core side
  input  wire logic [pad_pkg::NMioPads-1:0]                    mio_out_i,
  input  wire logic [pad_pkg::NMioPads-1:0]                    mio_oe_i,
  output logic      [pad_pkg::NMioPads-1:0]                    mio_in_o,
  input  wire logic [pad_pkg::NDioPads-1:0]                    dio_out_i,
  input  wire logic [pad_pkg::NDioPads-1:0]                    dio_oe_i,
  output logic      [pad_pkg::NDioPads-1:0]                    dio_in_o,
  input  wire logic [pad_pkg::NMioPads-1:0][pad_pkg::AttrDw-1:0] mio_attr_i,
  input  wire logic [pad_pkg::NDioPads-1:0][pad_pkg::AttrDw-1:0] dio_attr_i,
  // Pad side
  input  wire logic [pad_pkg::NMioPads-1:0]                    mio_pad_i,
  output logic      [pad_pkg::NMioPads-1:0]                    mio_pad_o,
  output logic      [pad_pkg::NMioPads-1:0]                    mio_pad_oe_o,
  input  wire logic [pad_pkg::NDioPads-1:0]                    dio_pad_i,
  output logic      [pad_pkg::NDioPads-1:0]                    dio_pad_o,
  output logic      [pad_pkg::NDioPads-1:0]                    dio_pad_oe_o
);

  localparam int NPads = pad_pkg::NMioPads + pad_pkg::NDioPads;

  // DIO pads sit above the MIO pads and are always connected
  logic [NPads-1:0]                      core_out, core_oe, core_in;
  logic [NPads-1:0]                      pad_in, pad_out, pad_oe;
  logic [NPads-1:0]                      conn_in, conn_out;
  logic [NPads-1:0][pad_pkg::AttrDw-1:0] attr;

  assign core_out = {dio_out_i, mio_out_i};
  assign core_oe  = {dio_oe_i, mio_oe_i};
  assign pad_in   = {dio_pad_i, mio_pad_i};
  assign attr     = {dio_attr_i, mio_attr_i};
  assign conn_in  = {{pad_pkg::NDioPads{1'b1}}, ConnectMioIn};
  assign conn_out = {{pad_pkg::NDioPads{1'b1}}, ConnectMioOut};

  always_comb begin
    for (int i = 0; i < NPads; i++) begin
      pad_out[i] = conn_out[i] & (core_out[i] ^ attr[i][pad_pkg::AttrInvert]);
      // Open drain only drives the low level
      pad_oe[i]  = conn_out[i] & core_oe[i] &
                   (~attr[i][pad_pkg::AttrOpenDrain] | ~pad_out[i]);
      core_in[i] = conn_in[i] & (pad_in[i] ^ attr[i][pad_pkg::AttrInvert]);
    end
  end

  assign {dio_pad_o, mio_pad_o}       = pad_out;
  assign {dio_pad_oe_o, mio_pad_oe_o} = pad_oe;
  assign {dio_in_o, mio_in_o}         = core_in;

endmodule : padring

`default_nettype wire

/* periph_pkg.sv */
// Configuration bus geometry, register map and pin mux source codes
// Used by the register block, the pin mux and the bus interface
`default_nettype none

package periph_pkg;

  // Bus widths
  parameter int CfgAw = 4;
  parameter int CfgDw = 32;

  ////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////

  parameter logic [CfgAw-1:0] RegGpioOut  = 4'd0;
  parameter logic [CfgAw-1:0] RegGpioOe   = 4'd1;
  // Read only, synchronized pad inputs
  parameter logic [CfgAw-1:0] RegGpioIn   = 4'd2;
  // One bit per MIO pad
  parameter logic [CfgAw-1:0] RegMuxSel   = 4'd3;
  parameter logic [CfgAw-1:0] RegMioAttr  = 4'd4;
  parameter logic [CfgAw-1:0] RegDioAttr  = 4'd5;
  // Write launches one frame
  parameter logic [CfgAw-1:0] RegUartData = 4'd6;
  // Read only, bit 0 busy, bit 1 sense
  parameter logic [CfgAw-1:0] RegStatus   = 4'd7;

  // Mux select values
  parameter logic MuxSrcGpio = 1'b0;
  parameter logic MuxSrcUart = 1'b1;

endpackage : periph_pkg

`default_nettype wire

/* pinmux.sv */
// MIO source selection and input synchronization
// Each pad carries its GPIO bit or the UART line, inputs pass two flops
`timescale 1ns/1ps
`default_nettype none

module pinmux (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic [pad_pkg::NMioPads-1:0] mux_sel_i,
  input  wire logic [pad_pkg::NMioPads-1:0] gpio_out_i,
  input  wire logic [pad_pkg::NMioPads-1:0] gpio_oe_i,
  input  wire logic                         uart_tx_i,
  input  wire logic [pad_pkg::NMioPads-1:0] mio_in_i,
  input  wire logic                         dio_sense_i,
  output logic      [pad_pkg::NMioPads-1:0] mio_out_o,
  output logic      [pad_pkg::NMioPads-1:0] mio_oe_o,
  output logic      [pad_pkg::NMioPads-1:0] gpio_in_o,
  output logic                              sense_o
);

  // Sense bit rides on top of the MIO inputs
  logic [pad_pkg::NMioPads:0] sync1_q, sync2_q;

  always_comb begin
    for (int i = 0; i < pad_pkg::NMioPads; i++) begin
      if (mux_sel_i[i] == periph_pkg::MuxSrcUart) begin
        mio_out_o[i] = uart_tx_i;
        mio_oe_o[i]  = 1'b1;
      end else begin
        mio_out_o[i] = gpio_out_i[i];
        mio_oe_o[i]  = gpio_oe_i[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= {dio_sense_i, mio_in_i};
      sync2_q <= sync1_q;
    end
  end

  assign gpio_in_o = sync2_q[pad_pkg::NMioPads-1:0];
  assign sense_o   = sync2_q[pad_pkg::NMioPads];

endmodule : pinmux

`default_nettype wire

/* rst_ctrl.sv */
// Board reset conditioning
// Synchronizes reset_i and stretches the release by a fixed count
`timescale 1ns/1ps
`default_nettype none

module rst_ctrl #(
  parameter int RstHoldCycles = 4
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  output logic      rst_o
);

  localparam int CntW = (RstHoldCycles > 0) ? $clog2(RstHoldCycles + 1) : 1;

  logic [1:0]      sync_q;
  logic [CntW-1:0] cnt_q;
  logic            rst_q;

  // Two-flop synchronizer, held set while reset_i is high
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], 1'b0};
    end
  end

  // Count clean cycles before release
  always_ff @(posedge clk_i) begin
    if (sync_q[1]) begin
      cnt_q <= '0;
      rst_q <= 1'b1;
    end else if (cnt_q != CntW'(RstHoldCycles)) begin
      cnt_q <= cnt_q + 1'b1;
    end else begin
      rst_q <= 1'b0;
    end
  end

  assign rst_o = rst_q;

endmodule : rst_ctrl

`default_nettype wire

/* tb_chip_board_top.sv */
// Directed testbench for the board-level I/O subsystem
// Drives the config bus and pads, checks pads, registers and UART frames
`timescale 1ns/1ps
`default_nettype none

module tb_chip_board_top;

  localparam int                           ClkPeriod     = 10;
  localparam int                           ClksPerBit    = 8;
  localparam int                           RstHoldCycles = 4;
  localparam logic [pad_pkg::NMioPads-1:0] ConnMask      = 16'h0FFF;
  localparam int                           NumTests      = 6;
  localparam int                           FrameCycles   = 10 * ClksPerBit;
  // Generous budget per test, dominated by UART frames
  localparam int TimeoutCycles = 8 + NumTests * (4 * FrameCycles + 200);

  logic                         clk;
  logic                         reset;
  logic                         cfg_req, cfg_we, cfg_ack;
  logic [periph_pkg::CfgAw-1:0] cfg_addr;
  logic [periph_pkg::CfgDw-1:0] cfg_wdata, cfg_rdata;
  logic [pad_pkg::NMioPads-1:0] mio_pad_in, mio_pad_out, mio_pad_oe;
  logic [pad_pkg::NDioPads-1:0] dio_pad_in, dio_pad_out, dio_pad_oe;
  int                           errors = 0;

  chip_board_top #(
    .ClksPerBit    (ClksPerBit),
    .RstHoldCycles (RstHoldCycles),
    .ConnectMioIn  (ConnMask),
    .ConnectMioOut (ConnMask)
  ) dut (
    .io_clk_i     (clk),
    .reset_i      (reset),
    .cfg_req_i    (cfg_req),
    .cfg_we_i     (cfg_we),
    .cfg_addr_i   (cfg_addr),
    .cfg_wdata_i  (cfg_wdata),
    .cfg_ack_o    (cfg_ack),
    .cfg_rdata_o  (cfg_rdata),
    .mio_pad_i    (mio_pad_in),
    .mio_pad_o    (mio_pad_out),
    .mio_pad_oe_o (mio_pad_oe),
    .dio_pad_i    (dio_pad_in),
    .dio_pad_o    (dio_pad_out),
    .dio_pad_oe_o (dio_pad_oe)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Timeout: tests did not finish within %0d clock cycles", TimeoutCycles);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic expect_eq(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  // Returns on the falling edge where ack is at the given level
  task automatic wait_ack(input logic level);
    @(negedge clk);
    while (cfg_ack !== level) @(negedge clk);
  endtask

  task automatic bus_write(input logic [periph_pkg::CfgAw-1:0] addr,
                           input logic [periph_pkg::CfgDw-1:0] data);
    @(negedge clk);
    cfg_req   = 1'b1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    wait_ack(1'b1);
    cfg_req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic bus_read(input logic [periph_pkg::CfgAw-1:0] addr,
                          output logic [periph_pkg::CfgDw-1:0] data);
    @(negedge clk);
    cfg_req   = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = addr;
    cfg_wdata = '0;
    wait_ack(1'b1);
    data    = cfg_rdata;
    cfg_req = 1'b0;
    wait_ack(1'b0);
  endtask

  // Packs per-pad invert and open-drain bits into a RegMioAttr word
  function automatic logic [31:0] mio_attr_word(input logic [15:0] inv, input logic [15:0] od);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < pad_pkg::NMioPads; i++) begin
      w[i*pad_pkg::AttrDw + pad_pkg::AttrInvert]    = inv[i];
      w[i*pad_pkg::AttrDw + pad_pkg::AttrOpenDrain] = od[i];
    end
    return w;
  endfunction

  // Samples each bit a little before its middle, starting from the ack edge
  task automatic check_frame(input logic [7:0] data, input logic [15:0] sel);
    logic [9:0] bits;
    bits = {1'b1, data, 1'b0};
    repeat (ClksPerBit / 2 - 1) @(negedge clk);
    for (int k = 0; k < 10; k++) begin
      if (k > 0) begin
        repeat (ClksPerBit) @(negedge clk);
      end
      expect_eq("UART bit on DIO 0", 32'(dio_pad_out[pad_pkg::DioUartTx]), 32'(bits[k]));
      expect_eq("UART bit on routed MIO", 32'(mio_pad_out & sel), bits[k] ? 32'(sel) : 32'h0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state_test();
    logic [31:0]                  rd;
    logic [periph_pkg::CfgAw-1:0] addr;
    // Request pending while the reset stretch runs
    cfg_req  = 1'b1;
    cfg_we   = 1'b0;
    cfg_addr = periph_pkg::RegGpioOut;
    reset    = 1'b0;
    for (int i = 0; i < RstHoldCycles + 2; i++) begin
      @(negedge clk);
      expect_eq("ack during reset hold", 32'(cfg_ack), 32'h0);
    end
    wait_ack(1'b1);
    expect_eq("first read after reset", cfg_rdata, 32'h0);
    cfg_req = 1'b0;
    wait_ack(1'b0);
    expect_eq("MIO enables after reset", 32'(mio_pad_oe), 32'h0);
    expect_eq("UART pad level after reset", 32'(dio_pad_out[pad_pkg::DioUartTx]), 32'h1);
    expect_eq("UART pad enable after reset", 32'(dio_pad_oe[pad_pkg::DioUartTx]), 32'h1);
    expect_eq("sense pad enable after reset", 32'(dio_pad_oe[pad_pkg::DioSense]), 32'h0);
    for (int a = 0; a < 8; a++) begin
      addr = a[periph_pkg::CfgAw-1:0];
      bus_read(addr, rd);
      expect_eq($sformatf("register %0d after reset", a), rd, 32'h0);
    end
  endtask

  task automatic gpio_output_test();
    logic [15:0] out, oe;
    logic [31:0] rd;
    out = 16'($urandom);
    oe  = 16'($urandom);
    bus_write(periph_pkg::RegGpioOut, 32'(out));
    bus_write(periph_pkg::RegGpioOe, 32'(oe));
    expect_eq("GPIO pad outputs", 32'(mio_pad_out), 32'(out & ConnMask));
    expect_eq("GPIO pad enables", 32'(mio_pad_oe), 32'(oe & ConnMask));
    bus_read(periph_pkg::RegGpioOut, rd);
    expect_eq("RegGpioOut readback", rd, 32'(out));
    bus_read(periph_pkg::RegGpioOe, rd);
    expect_eq("RegGpioOe readback", rd, 32'(oe));
    bus_write(periph_pkg::RegGpioOut, 32'h0);
    bus_write(periph_pkg::RegGpioOe, 32'h0);
  endtask

  task automatic gpio_input_test();
    logic [15:0] pad, inv;
    logic [31:0] rd;
    pad = 16'($urandom);
    inv = 16'($urandom);
    bus_write(periph_pkg::RegMioAttr, mio_attr_word(inv, 16'h0));
    @(negedge clk);
    mio_pad_in = pad;
    // Two synchronizer flops, plus margin
    repeat (3) @(negedge clk);
    bus_read(periph_pkg::RegGpioIn, rd);
    expect_eq("RegGpioIn with invert", rd, 32'((pad ^ inv) & ConnMask));
    bus_write(periph_pkg::RegMioAttr, 32'h0);
    mio_pad_in = '0;
  endtask

  task automatic open_drain_test();
    int          p;
    logic [15:0] bit_mask;
    logic        inv_b, out_b, exp_out, exp_oe;
    p        = int'($urandom_range(11, 0));
    bit_mask = 16'h1 << p;
    bus_write(periph_pkg::RegGpioOe, 32'(bit_mask));
    for (int inv = 0; inv < 2; inv++) begin
      for (int out = 0; out < 2; out++) begin
        inv_b   = inv[0];
        out_b   = out[0];
        exp_out = out_b ^ inv_b;
        // Enable only while the pad drives low
        exp_oe  = ~exp_out;
        bus_write(periph_pkg::RegMioAttr, mio_attr_word(inv_b ? bit_mask : 16'h0, bit_mask));
        bus_write(periph_pkg::RegGpioOut, out_b ? 32'(bit_mask) : 32'h0);
        expect_eq($sformatf("open-drain pad %0d level", p), 32'(mio_pad_out[p]), 32'(exp_out));
        expect_eq($sformatf("open-drain pad %0d enable", p), 32'(mio_pad_oe[p]), 32'(exp_oe));
      end
    end
    bus_write(periph_pkg::RegMioAttr, 32'h0);
    bus_write(periph_pkg::RegGpioOut, 32'h0);
    bus_write(periph_pkg::RegGpioOe, 32'h0);
  endtask

  task automatic uart_frame_test();
    logic [15:0] sel;
    logic [7:0]  data, data2;
    logic [31:0] rd;
    sel   = (16'($urandom) & ConnMask) | 16'h0001;
    data  = 8'($urandom);
    data2 = ~data;
    bus_write(periph_pkg::RegMuxSel, 32'(sel));
    expect_eq("routed pad enables", 32'(mio_pad_oe), 32'(sel));
    expect_eq("routed pads idle high", 32'(mio_pad_out), 32'(sel));
    @(negedge clk);
    cfg_req   = 1'b1;
    cfg_we    = 1'b1;
    cfg_addr  = periph_pkg::RegUartData;
    cfg_wdata = 32'(data);
    wait_ack(1'b1);
    fork
      check_frame(data, sel);
      begin
        cfg_req = 1'b0;
        wait_ack(1'b0);
        bus_read(periph_pkg::RegStatus, rd);
        expect_eq("status busy mid-frame", rd, 32'h1);
        // Dropped while busy
        bus_write(periph_pkg::RegUartData, 32'(data2));
        bus_read(periph_pkg::RegUartData, rd);
        expect_eq("RegUartData keeps first byte", rd, 32'(data));
      end
    join
    repeat (ClksPerBit) @(negedge clk);
    bus_read(periph_pkg::RegStatus, rd);
    expect_eq("status idle after frame", rd, 32'h0);
    repeat (FrameCycles) begin
      @(negedge clk);
      expect_eq("line idle, no second frame", 32'(dio_pad_out[pad_pkg::DioUartTx]), 32'h1);
    end
    bus_write(periph_pkg::RegMuxSel, 32'h0);
  endtask

  task automatic sense_input_test();
    logic        inv_b, pv_b;
    logic [31:0] rd;
    for (int inv = 0; inv < 2; inv++) begin
      for (int pv = 0; pv < 2; pv++) begin
        inv_b = inv[0];
        pv_b  = pv[0];
        bus_write(periph_pkg::RegDioAttr,
                  32'(inv_b) << (pad_pkg::DioSense * pad_pkg::AttrDw + pad_pkg::AttrInvert));
        @(negedge clk);
        dio_pad_in[pad_pkg::DioSense] = pv_b;
        repeat (3) @(negedge clk);
        bus_read(periph_pkg::RegStatus, rd);
        expect_eq($sformatf("sense pad %0d invert %0d", pv, inv), rd, 32'({pv_b ^ inv_b, 1'b0}));
      end
    end
    bus_write(periph_pkg::RegDioAttr, 32'h0);
    dio_pad_in = '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h5d22));
    reset      = 1'b1;
    cfg_req    = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    mio_pad_in = '0;
    dio_pad_in = '0;
    repeat (8) @(negedge clk);
    reset_state_test();
    gpio_output_test();
    gpio_input_test();
    open_drain_test();
    uart_frame_test();
    sense_input_test();
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1, "%0d checks did not match", errors);
    end
  end

endmodule : tb_chip_board_top

`default_nettype wire

/* uart_tx.sv */
// 8N1 serial transmitter
// One frame per start pulse, line idles high, bit period is ClksPerBit
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int ClksPerBit = 8
) (
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  input  wire logic       start_i,
  input  wire logic [7:0] data_i,
  output logic            tx_o,
  output logic            busy_o
);

  localparam int CntW = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;
  // Start, eight data bits, stop
  localparam int FrameBits = 10;

  logic [FrameBits-1:0] shift_q;
  logic [3:0]           bit_q;
  logic [CntW-1:0]      cnt_q;
  logic                 busy_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      shift_q <= '1;
      bit_q   <= '0;
      cnt_q   <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (start_i) begin
        shift_q <= {1'b1, data_i, 1'b0};
        bit_q   <= '0;
        cnt_q   <= '0;
        busy_q  <= 1'b1;
      end
    end else if (cnt_q == CntW'(ClksPerBit - 1)) begin
      cnt_q   <= '0;
      // Ones shift in behind the frame, so the line ends high
      shift_q <= {1'b1, shift_q[FrameBits-1:1]};
      if (bit_q == 4'(FrameBits - 1)) begin
        busy_q <= 1'b0;
      end else begin
        bit_q <= bit_q + 1'b1;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tx_o   = shift_q[0];
  assign busy_o = busy_q;

endmodule : uart_tx

`default_nettype wire
